// ==== fc_checker.sv ====
////////////////////
// scoreboard for the fc engine testbench
// snoops the DUT ports, models every row and compares results
////////////////////
`timescale 1ns/1ps

module fc_checker (
  input  logic          clk,
  input  logic          rstn,
  input  logic [2:0]    command,
  input  fc_pkg::size_t size,
  input  fc_pkg::word_t s_tdata,
  input  logic          s_tvalid,
  input  logic          s_tready,
  input  logic          s_tlast,
  input  fc_pkg::word_t m_tdata,
  input  logic          m_tvalid,
  input  logic          m_tready,
  input  logic          m_tlast,
  input  logic          f_writedone,
  input  logic          b_writedone,
  input  logic          w_writedone,
  input  logic          fc_done,
  output int            data_errors,
  output int            proto_errors,
  output int            results_checked,
  output int            pending,
  output int            f_pulses,
  output int            b_pulses,
  output int            w_pulses,
  output int            done_pulses
);
  import fc_pkg::*;

  localparam int MODE_IDLE   = 0;
  localparam int MODE_FEAT   = 1;
  localparam int MODE_BIAS   = 2;
  localparam int MODE_WEIGHT = 3;

  word_t feat_words [256];
  int    bias_mem [256];
  int    exp_q [$];        // expected results in order
  bit    last_q [$];
  int    mode, wr_idx, row_words, word_idx, neuron, acc, loads;
  string test_name;
  bit    fdone_due, bdone_due, end_due, ready_due;
  bit    held, held_last;
  word_t held_data;

  // signed int8 dot product of one word pair
  function automatic int lane_dot(input word_t f, input word_t w);
    byte fa;
    byte wa;
    int  s;
    s = 0;
    for (int i = 0; i < LANES; i++) begin
      fa = f[8*i +: 8];
      wa = w[8*i +: 8];
      s += int'(fa) * int'(wa);
    end
    return s;
  endfunction

  task automatic check_pulse(input logic seen, input bit due, input string what);
    if (seen !== due) begin
      proto_errors++;
      $display("%s: %s %s", test_name, what,
               due ? "did not pulse when expected" : "pulsed when no pulse was due");
    end
  endtask

  ////////////////////
  // master stream
  ////////////////////
  task automatic check_output();
    int exp;
    bit lst;
    if (held && !m_tvalid) begin
      proto_errors++;
      $display("%s: m_tvalid dropped before the result was accepted", test_name);
    end else if (held && m_tdata !== held_data) begin
      data_errors++;
      $display("** Error %s: m_tdata changed while stalled, expected %h actual %h",
               test_name, held_data, m_tdata);
    end else if (held && m_tlast !== held_last) begin
      proto_errors++;
      $display("%s: m_tlast changed while stalled", test_name);
    end
    held = m_tvalid && !m_tready;
    held_data = m_tdata;
    held_last = m_tlast;
    if (m_tvalid && m_tready) begin
      if (exp_q.size() == 0) begin
        proto_errors++;
        $display("%s: result accepted with no row to match it", test_name);
      end else begin
        exp = exp_q.pop_front();
        lst = last_q.pop_front();
        if (m_tdata !== word_t'(exp)) begin
          data_errors++;
          $display("** Error %s: result %0d expected %h actual %h",
                   test_name, results_checked, word_t'(exp), m_tdata);
        end
        if (m_tlast !== lst) begin
          data_errors++;
          $display("** Error %s: m_tlast of result %0d expected %0b actual %0b",
                   test_name, results_checked, lst, m_tlast);
        end
        results_checked++;
        end_due = lst;    // done pulses follow the last result
      end
    end
  endtask

  task automatic snoop_command();
    ready_due = |command;   // s_tready rises on the next cycle
    if (command[0]) begin
      mode = MODE_FEAT;
      wr_idx = 0;
      row_words = int'(size) / 4;
      loads++;
      test_name = $sformatf("feature_load_%0d", loads);
    end else if (command[1]) begin
      mode = MODE_BIAS;
      wr_idx = 0;
      test_name = $sformatf("bias_load_%0d", loads);
    end else if (command[2]) begin
      mode = MODE_WEIGHT;
      word_idx = 0;
      neuron = 0;
      acc = 0;
      test_name = $sformatf("weights_%0d", loads);
    end
  endtask

  ////////////////////
  // slave stream model
  ////////////////////
  task automatic snoop_beat();
    if (!(s_tvalid && s_tready)) return;
    case (mode)
      MODE_FEAT, MODE_BIAS: begin
        if (mode == MODE_FEAT) begin
          feat_words[wr_idx] = s_tdata;
        end else begin
          bias_mem[wr_idx] = s_tdata;
        end
        wr_idx++;
        if (s_tlast) begin
          fdone_due = (mode == MODE_FEAT);
          bdone_due = (mode == MODE_BIAS);
          mode = MODE_IDLE;
        end
      end
      MODE_WEIGHT: begin
        acc += lane_dot(feat_words[word_idx], s_tdata);
        word_idx++;
        if (word_idx == row_words) begin
          exp_q.push_back(acc + bias_mem[neuron]);    // wraps mod 2^32
          last_q.push_back(s_tlast);
          neuron++;
          word_idx = 0;
          acc = 0;
          if (s_tlast) mode = MODE_IDLE;
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    if (!rstn) begin
      mode = MODE_IDLE;
      loads = 0;
      test_name = "reset";
      {fdone_due, bdone_due, end_due, ready_due, held} = '0;
      {data_errors, proto_errors, results_checked, pending} = '0;
      {f_pulses, b_pulses, w_pulses, done_pulses} = '0;
    end else begin
      if (f_writedone) f_pulses++;
      if (b_writedone) b_pulses++;
      if (w_writedone) w_pulses++;
      if (fc_done) done_pulses++;
      check_pulse(f_writedone, fdone_due, "f_writedone");
      check_pulse(b_writedone, bdone_due, "b_writedone");
      check_pulse(w_writedone, end_due, "w_writedone");
      check_pulse(fc_done, end_due, "fc_done");
      if (ready_due && !s_tready) begin
        proto_errors++;
        $display("%s: s_tready did not rise the cycle after the command", test_name);
      end
      // no beat may be taken in idle or while a row result is outstanding
      if (s_tready && (mode == MODE_IDLE || (mode == MODE_WEIGHT && exp_q.size() != 0))) begin
        proto_errors++;
        $display("%s: s_tready high while no beat may be taken", test_name);
      end
      {fdone_due, bdone_due, end_due, ready_due} = '0;
      check_output();
      snoop_command();
      snoop_beat();
      pending = exp_q.size();
    end
  end

endmodule

// ==== fc_decode.sv ====
////////////////////
// command decode and slave stream control
// loads features and biases, pairs weight beats with stored
// features and issues one mac item per weight word
////////////////////
`timescale 1ns/1ps

module fc_decode #(
  parameter int FEAT_DEPTH = fc_pkg::FEAT_DEPTH_DEF
) (
  input  logic          clk,
  input  logic          rstn,
  input  logic [2:0]    command,
  input  fc_pkg::size_t size,
  input  fc_pkg::word_t s_tdata,
  input  logic          s_tvalid,
  input  logic          s_tlast,
  input  logic          result_sent,
  output logic          s_tready,
  output logic          f_writedone,
  output logic          b_writedone,
  output logic          w_writedone,
  output logic          final_row,
  fc_mac_if.src         mac
);
  import fc_pkg::*;

  localparam int AW = $clog2(2 * FEAT_DEPTH);
  typedef logic [AW-1:0] addr_t;

  fc_state_e       state;
  wcnt_t           row_words;   // latched on feature load
  wcnt_t           word_idx;    // word within the current row
  logic [AW-2:0]   neuron_idx;
  addr_t           wr_addr;
  word_t           weight_q;
  word_t           feat_rdata;
  word_t           bias_rdata;
  logic            item_v, item_first, item_last;
  logic            beat, we, row_first, row_last;

  assign beat      = s_tvalid & s_tready;
  assign we        = beat & (state == st_recv_feat || state == st_recv_bias);
  assign row_first = (word_idx == '0);
  assign row_last  = (word_idx == row_words - 1'b1);

  fc_feat_buffer #(.DEPTH(FEAT_DEPTH)) u_buf (
    .clk,
    .we,
    .waddr      (wr_addr),
    .wdata      (s_tdata),
    .feat_raddr (addr_t'(word_idx)),
    .bias_raddr (addr_t'(FEAT_DEPTH) + addr_t'(neuron_idx)),
    .feat_rdata,
    .bias_rdata
  );

  ////////////////////
  // state machine
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= st_idle;
      s_tready    <= 1'b0;
      f_writedone <= 1'b0;
      b_writedone <= 1'b0;
      w_writedone <= 1'b0;
      final_row   <= 1'b0;
      row_words   <= '0;
      word_idx    <= '0;
      neuron_idx  <= '0;
      wr_addr     <= '0;
    end else begin
      f_writedone <= 1'b0;
      b_writedone <= 1'b0;
      w_writedone <= 1'b0;
      case (state)
        st_idle: begin
          if (command[0]) begin
            state     <= st_recv_feat;
            s_tready  <= 1'b1;
            wr_addr   <= '0;
            row_words <= size[10:2];  // four features per word
          end else if (command[1]) begin
            state    <= st_recv_bias;
            s_tready <= 1'b1;
            wr_addr  <= addr_t'(FEAT_DEPTH);
          end else if (command[2]) begin
            state      <= st_recv_weight;
            s_tready   <= 1'b1;
            word_idx   <= '0;
            neuron_idx <= '0;
          end
        end
        st_recv_feat, st_recv_bias: begin
          if (beat) begin
            wr_addr <= wr_addr + 1'b1;
            if (s_tlast) begin
              s_tready    <= 1'b0;
              state       <= st_idle;
              f_writedone <= (state == st_recv_feat);
              b_writedone <= (state == st_recv_bias);
            end
          end
        end
        st_recv_weight: begin
          if (beat) begin
            if (row_last) begin
              // stall until this row's result is taken
              word_idx   <= '0;
              neuron_idx <= neuron_idx + 1'b1;
              s_tready   <= 1'b0;
              final_row  <= s_tlast;
              state      <= st_wait_result;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        st_wait_result: begin
          if (result_sent) begin
            if (final_row) begin
              w_writedone <= 1'b1;
              state       <= st_idle;
            end else begin
              s_tready <= 1'b1;
              state    <= st_recv_weight;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////
  // item issue, two cycles after the weight beat
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      item_v    <= 1'b0;
      mac.valid <= 1'b0;
    end else begin
      item_v    <= beat & (state == st_recv_weight);
      mac.valid <= item_v;
    end
  end

  always_ff @(posedge clk) begin
    weight_q   <= s_tdata;      // held while the feature word is read
    item_first <= row_first;
    item_last  <= row_last;
    mac.feat   <= feat_rdata;
    mac.weight <= weight_q;
    mac.first  <= item_first;
    mac.last   <= item_last;
    mac.bias   <= bias_rdata;
  end

  a_cmd_onehot: assert property (@(posedge clk) disable iff (!rstn)
    state == st_idle |-> $onehot0(command));

endmodule

// ==== fc_execute.sv ====
////////////////////
// four-lane multiply, lane sum and row accumulation
// emits the row dot product with its bias on the last item
////////////////////
`timescale 1ns/1ps

module fc_execute (
  input  logic         clk,
  input  logic         rstn,
  fc_mac_if.dst        mac,
  output logic         dot_valid,
  output fc_pkg::acc_t dot,
  output fc_pkg::acc_t dot_bias
);
  import fc_pkg::*;

  prod_t                prod [LANES];
  logic [PE_STAGES-1:0] v_d, f_d, l_d;   // aligned with the products
  acc_t                 bias_d [PE_STAGES];
  acc_t                 lane_total, lane_sum, acc_q, sum_bias;
  logic                 sum_v, sum_first, sum_last;
  logic                 row_open;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    fc_pe_mult u_pe (
      .clk,
      .a (mac.feat[8*i +: 8]),
      .b (mac.weight[8*i +: 8]),
      .p (prod[i])
    );
  end

  always_comb begin
    lane_total = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_total += acc_t'(prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_d       <= '0;
      f_d       <= '0;
      l_d       <= '0;
      sum_v     <= 1'b0;
      sum_first <= 1'b0;
      sum_last  <= 1'b0;
      dot_valid <= 1'b0;
      row_open  <= 1'b0;
    end else begin
      v_d       <= {v_d[PE_STAGES-2:0], mac.valid};
      f_d       <= {f_d[PE_STAGES-2:0], mac.first};
      l_d       <= {l_d[PE_STAGES-2:0], mac.last};
      sum_v     <= v_d[PE_STAGES-1];
      sum_first <= f_d[PE_STAGES-1];
      sum_last  <= l_d[PE_STAGES-1];
      dot_valid <= sum_v & sum_last;
      if (mac.valid) begin
        row_open <= ~mac.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    bias_d[0] <= mac.bias;
    for (int i = 1; i < PE_STAGES; i++) begin
      bias_d[i] <= bias_d[i-1];
    end
    lane_sum <= lane_total;               // one register stage for the sum
    sum_bias <= bias_d[PE_STAGES-1];
    if (sum_v) begin
      acc_q <= sum_first ? lane_sum : acc_q + lane_sum;
    end
    if (sum_v && sum_last) begin
      dot_bias <= sum_bias;
    end
  end

  assign dot = acc_q;

  a_row_first: assert property (@(posedge clk) disable iff (!rstn)
    mac.valid && mac.first |-> !row_open);

endmodule

// ==== fc_feat_buffer.sv ====
////////////////////
// feature and bias store, one write port and two read ports
// features in the lower half, biases in the upper half
////////////////////
`timescale 1ns/1ps

module fc_feat_buffer #(
  parameter int DEPTH = fc_pkg::FEAT_DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         we,
  input  logic [$clog2(2*DEPTH)-1:0]   waddr,
  input  fc_pkg::word_t                wdata,
  input  logic [$clog2(2*DEPTH)-1:0]   feat_raddr,
  input  logic [$clog2(2*DEPTH)-1:0]   bias_raddr,
  output fc_pkg::word_t                feat_rdata,
  output fc_pkg::word_t                bias_rdata
);
  import fc_pkg::*;

  word_t mem [2*DEPTH];

  // both reads registered with one cycle of latency
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    feat_rdata <= mem[feat_raddr];
    bias_rdata <= mem[bias_raddr];
  end

endmodule

// ==== fc_mac_if.sv ====
////////////////////
// multiply-accumulate items from decode to execute
// one item per valid strobe, execute always takes it
////////////////////
`timescale 1ns/1ps

interface fc_mac_if;
  import fc_pkg::*;

  logic  valid;   // one-cycle strobe
  word_t feat;    // four packed int8 features
  word_t weight;  // four packed int8 weights
  logic  first;   // opens a row
  logic  last;    // closes a row
  acc_t  bias;    // only meaningful with last

  modport src (output valid, feat, weight, first, last, bias);
  modport dst (input valid, feat, weight, first, last, bias);

endinterface

// ==== fc_pe_mult.sv ====
////////////////////
// pipelined signed 8x8 multiplier
// multiplies magnitudes with shifted partial-product rows,
// then restores the sign in the last stage
////////////////////
`timescale 1ns/1ps

module fc_pe_mult (
  input  logic          clk,
  input  fc_pkg::lane_t a,
  input  fc_pkg::lane_t b,
  output fc_pkg::prod_t p
);
  import fc_pkg::*;

  logic [7:0]           a_mag, b_mag;
  logic [7:0]           pp_q [8];     // partial-product rows
  logic [9:0]           pair_q [4];
  logic [11:0]          quad_q [2];
  logic [15:0]          total;
  logic [PE_STAGES-2:0] sign_d;

  // -128 maps to 8'h80 which is still a valid magnitude
  assign a_mag = a[7] ? 8'(-a) : a;
  assign b_mag = b[7] ? 8'(-b) : b;

  assign total = {4'h0, quad_q[0]} + {quad_q[1], 4'h0};

  always_ff @(posedge clk) begin
    // stage 1 rows
    for (int i = 0; i < 8; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : 8'd0;
    end
    // stage 2 adjacent rows
    for (int j = 0; j < 4; j++) begin
      pair_q[j] <= {2'b00, pp_q[2*j]} + {1'b0, pp_q[2*j+1], 1'b0};
    end
    // stage 3 pairs of pairs
    for (int k = 0; k < 2; k++) begin
      quad_q[k] <= {2'b00, pair_q[2*k]} + {pair_q[2*k+1], 2'b00};
    end
    sign_d <= {sign_d[PE_STAGES-3:0], a[7] ^ b[7]};
    // stage 4 final sum and sign fix
    p <= sign_d[PE_STAGES-2] ? -$signed(total) : $signed(total);
  end

endmodule

// ==== fc_pkg.sv ====
////////////////////
// common types and constants for the int8 fully-connected engine
// every design unit imports what it needs from here
////////////////////
package fc_pkg;

  typedef logic [31:0]        word_t;  // one stream beat
  typedef logic signed [7:0]  lane_t;  // int8 feature or weight
  typedef logic signed [15:0] prod_t;  // 8x8 signed product
  typedef logic signed [31:0] acc_t;   // accumulator, bias and result
  typedef logic [10:0]        size_t;  // feature count from the host
  typedef logic [8:0]         wcnt_t;  // words per row, size/4

  localparam int LANES          = 4;   // int8 values per word
  localparam int PE_STAGES      = 4;   // multiplier latency
  localparam int FEAT_DEPTH_DEF = 256; // default feature words held

  // decode sequencing
  typedef enum logic [2:0] {
    st_idle,
    st_recv_feat,
    st_recv_bias,
    st_recv_weight,
    st_wait_result
  } fc_state_e;

endpackage

// ==== fc_result.sv ====
////////////////////
// bias add and master stream output
// holds each result until accepted, flags the last neuron
////////////////////
`timescale 1ns/1ps

module fc_result (
  input  logic          clk,
  input  logic          rstn,
  input  logic          dot_valid,
  input  fc_pkg::acc_t  dot,
  input  fc_pkg::acc_t  dot_bias,
  input  logic          final_row,
  input  logic          m_tready,
  output fc_pkg::word_t m_tdata,
  output logic          m_tvalid,
  output logic          m_tlast,
  output logic          result_sent,
  output logic          fc_done
);
  import fc_pkg::*;

  acc_t biased;

  assign biased      = dot + dot_bias;       // wraps to 32 bits
  assign result_sent = m_tvalid & m_tready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      fc_done  <= 1'b0;
    end else begin
      fc_done <= result_sent & m_tlast;
      if (dot_valid) begin
        m_tvalid <= 1'b1;
        m_tlast  <= final_row;
      end else if (result_sent) begin
        m_tvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dot_valid) begin
      m_tdata <= biased;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast));

endmodule

// ==== fc_top.sv ====
////////////////////
// int8 fully-connected layer engine, top level
// slave stream in, master stream out, command strobes
////////////////////
`timescale 1ns/1ps

module fc_top #(
  parameter int FEAT_DEPTH = fc_pkg::FEAT_DEPTH_DEF
) (
  input  logic          clk,
  input  logic          rstn,
  input  logic [2:0]    command,
  input  fc_pkg::size_t size,
  input  fc_pkg::word_t s_tdata,
  input  logic          s_tvalid,
  input  logic          s_tlast,
  output logic          s_tready,
  output fc_pkg::word_t m_tdata,
  output logic          m_tvalid,
  input  logic          m_tready,
  output logic          m_tlast,
  output logic          f_writedone,
  output logic          b_writedone,
  output logic          w_writedone,
  output logic          fc_done
);
  import fc_pkg::*;

  logic dot_valid, final_row, result_sent;
  acc_t dot, dot_bias;

  fc_mac_if mac ();

  fc_decode #(.FEAT_DEPTH(FEAT_DEPTH)) u_decode (
    .clk, .rstn, .command, .size, .s_tdata, .s_tvalid, .s_tlast,
    .result_sent, .s_tready, .f_writedone, .b_writedone, .w_writedone,
    .final_row, .mac (mac.src)
  );

  fc_execute u_execute (
    .clk, .rstn, .mac (mac.dst), .dot_valid, .dot, .dot_bias
  );

  fc_result u_result (
    .clk, .rstn, .dot_valid, .dot, .dot_bias, .final_row, .m_tready,
    .m_tdata, .m_tvalid, .m_tlast, .result_sent, .fc_done
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fc_top -f vlog.f -o fc_sim \
  && ./obj_dir/fc_sim | tee sim.log \
  && grep -q "^TEST PASSED$" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_fc_top.sv ====
////////////////////
// testbench for the int8 fully-connected engine
// two passes of feature, bias and weight loads with random gaps
// and random back-pressure, results checked by fc_checker
////////////////////
`timescale 1ns/1ps

module tb_fc_top;
  import fc_pkg::*;

  localparam int FEAT_DEPTH = 64;

  logic       clk;
  logic       rstn;
  logic [2:0] command;
  size_t      size;
  word_t      s_tdata, m_tdata;
  logic       s_tvalid, s_tready, s_tlast;
  logic       m_tvalid, m_tready, m_tlast;
  logic       f_writedone, b_writedone, w_writedone, fc_done;
  int         data_errors, proto_errors, results_checked, pending;
  int         f_pulses, b_pulses, w_pulses, done_pulses;
  int         size_a, size_b, rows_a, rows_b, end_errors;
  longint     timeout_ns;

  fc_top #(.FEAT_DEPTH(FEAT_DEPTH)) DUT (.*);

  fc_checker u_chk (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // about one stall cycle in four
  always @(negedge clk) begin
    if (rstn) m_tready = ($urandom % 4) != 0;
  end

  // int8 lanes with extra weight on -128 and 127
  function automatic word_t random_word();
    word_t w;
    for (int i = 0; i < LANES; i++) begin
      case ($urandom % 8)
        0: w[8*i +: 8] = 8'h80;
        1: w[8*i +: 8] = 8'h7f;
        default: w[8*i +: 8] = 8'($urandom);
      endcase
    end
    return w;
  endfunction

  ////////////////////
  // stream drivers, all on the falling edge
  ////////////////////
  task automatic issue_command(input logic [2:0] cmd, input int sz);
    command = cmd;
    size    = size_t'(sz);
    @(negedge clk);
    command = 3'b000;
  endtask

  task automatic send_beat(input word_t data, input logic last);
    while ($urandom % 4 == 0) begin
      @(negedge clk);         // idle gap
    end
    s_tdata  = data;
    s_tlast  = last;
    s_tvalid = 1'b1;
    while (!s_tready) begin
      @(negedge clk);
    end
    @(negedge clk);           // taken on the edge just passed
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic run_pass(input int sz, input int rows);
    issue_command(3'b001, sz);
    for (int w = 0; w < sz / 4; w++) begin
      send_beat(random_word(), w == sz / 4 - 1);
    end
    while (!f_writedone) @(negedge clk);
    @(negedge clk);
    issue_command(3'b010, 0);
    for (int r = 0; r < rows; r++) begin
      send_beat($urandom, r == rows - 1);   // full range biases
    end
    while (!b_writedone) @(negedge clk);
    @(negedge clk);
    issue_command(3'b100, 0);
    for (int r = 0; r < rows; r++) begin
      for (int w = 0; w < sz / 4; w++) begin
        send_beat(random_word(), r == rows - 1 && w == sz / 4 - 1);
      end
    end
    while (!fc_done) @(negedge clk);
    @(negedge clk);
  endtask

  initial begin
    void'($urandom(93));
    rstn       = 1'b0;
    command    = 3'b000;
    size       = '0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tlast    = 1'b0;
    m_tready   = 1'b0;
    end_errors = 0;
    size_a = 4 * (1 + $urandom % 32);
    rows_a = 2 + $urandom % 7;
    size_b = size_a;
    while (size_b == size_a) begin
      size_b = 4 * (1 + $urandom % 32);   // second pass needs a new row length
    end
    rows_b = 2 + $urandom % 7;
    // twenty cycles per beat covers gaps, stalls and row latency
    timeout_ns = 10 * (1000 + 20 * longint'(size_a / 4 * (rows_a + 1) + rows_a
                                          + size_b / 4 * (rows_b + 1) + rows_b));
    repeat (16) @(negedge clk);
    rstn = 1'b1;
    repeat (4) @(negedge clk);
    run_pass(size_a, rows_a);
    run_pass(size_b, rows_b);
    repeat (8) @(negedge clk);
    if (results_checked != rows_a + rows_b || pending != 0) begin
      end_errors++;
      $display("%0d results checked and %0d pending, %0d rows were sent",
               results_checked, pending, rows_a + rows_b);
    end
    if (f_pulses != 2 || b_pulses != 2 || w_pulses != 2 || done_pulses != 2) begin
      end_errors++;
      $display("pulse counts f %0d b %0d w %0d done %0d, two of each expected",
               f_pulses, b_pulses, w_pulses, done_pulses);
    end
    $display("errors: %0d data, %0d protocol, %0d end of run",
             data_errors, proto_errors, end_errors);
    if (data_errors + proto_errors + end_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    @(posedge rstn);
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
fc_pkg.sv
fc_mac_if.sv
fc_feat_buffer.sv
fc_decode.sv
fc_pe_mult.sv
fc_execute.sv
fc_result.sv
fc_top.sv
fc_checker.sv
tb_fc_top.sv
